// ==== verilog/isa_pkg.sv ====
package isa_pkg;

	////////////////////
	// major opcodes
	////////////////////
	localparam logic [5:0] op_rtype = 6'b000000;
	localparam logic [5:0] op_addiu = 6'b001001;
	localparam logic [5:0] op_beq   = 6'b000100;
	localparam logic [5:0] op_lw    = 6'b100011;
	localparam logic [5:0] op_sw    = 6'b101011;
	// reserved slot, stops the core
	localparam logic [5:0] op_halt  = 6'b111111;

	// function codes under op_rtype
	localparam logic [5:0] fn_addu = 6'b100001;
	localparam logic [5:0] fn_subu = 6'b100011;
	localparam logic [5:0] fn_and  = 6'b100100;
	localparam logic [5:0] fn_or   = 6'b100101;
	localparam logic [5:0] fn_slt  = 6'b101010;

	////////////////////
	// field positions
	////////////////////
	localparam int op_hi  = 31;
	localparam int op_lo  = 26;
	localparam int rs_hi  = 25;
	localparam int rs_lo  = 21;
	localparam int rt_hi  = 20;
	localparam int rt_lo  = 16;
	localparam int rd_hi  = 15;
	localparam int rd_lo  = 11;
	// function code, r-type only
	localparam int fn_hi  = 5;
	localparam int fn_lo  = 0;
	localparam int imm_hi = 15;
	localparam int imm_lo = 0;

	// alu operations
	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt
	} alu_op_e;

endpackage

// ==== verilog/core_pkg.sv ====
package core_pkg;

	// data and instruction width
	localparam int xlen = 32;

	// register index, 32 registers
	localparam int reg_addr_w = 5;

	// one machine word
	typedef logic [xlen-1:0] word_t;

	// instruction phases, one clock each
	// only one instruction in flight
	typedef enum logic [1:0] {
		ph_fetch,
		ph_decode,
		ph_execute,
		ph_result
	} phase_e;

endpackage

// ==== verilog/core_if.sv ====
`timescale 1ns/1ps

// register file read ports, decode side asks
interface rf_read_if;
	import core_pkg::*;

	logic [reg_addr_w-1:0] rs_addr;
	logic [reg_addr_w-1:0] rt_addr;
	// combinational, index zero reads zero
	word_t rs_data;
	word_t rt_data;

	modport requester (output rs_addr, output rt_addr, input rs_data, input rt_data);
	modport provider (input rs_addr, input rt_addr, output rs_data, output rt_data);
endinterface

// decoded instruction, stable through execute
interface dec_ex_if;
	import core_pkg::*;
	import isa_pkg::*;

	alu_op_e alu_op;
	word_t opa;
	word_t opb;
	word_t store_data;
	logic [reg_addr_w-1:0] dest;
	logic reg_we;
	logic is_load;
	logic is_store;
	logic is_branch;
	// sign-extended beq offset
	word_t branch_off;
	logic is_halt;
	word_t pc;

	modport source (output alu_op, opa, opb, store_data, dest, reg_we,
		is_load, is_store, is_branch, branch_off, is_halt, pc);
	modport sink (input alu_op, opa, opb, store_data, dest, reg_we,
		is_load, is_store, is_branch, branch_off, is_halt, pc);
endinterface

// execute results, held in the result phase
interface ex_res_if;
	import core_pkg::*;

	word_t result;
	logic [reg_addr_w-1:0] dest;
	logic reg_we;
	logic mem_we;
	word_t mem_addr;
	word_t pc;
	logic branch_taken;
	word_t next_pc;
	logic is_halt;

	modport source (output result, dest, reg_we, mem_we, mem_addr, pc,
		branch_taken, next_pc, is_halt);
	modport sink (input result, dest, reg_we, mem_we, mem_addr, pc, is_halt);
	// fetch side, pc redirect and halt
	modport consumer (input branch_taken, next_pc, is_halt);
endinterface

// ==== verilog/instr_mem.sv ====
`timescale 1ns/1ps

module instr_mem #(
	parameter int imem_words = 32
) (
	input  logic                          clk,
	input  logic                          prog_we,
	input  logic [$clog2(imem_words)-1:0] prog_addr,
	input  core_pkg::word_t               prog_data,
	input  core_pkg::word_t               addr,
	output core_pkg::word_t               instr
);
	import core_pkg::*;
	import isa_pkg::*;

	localparam int aw = $clog2(imem_words);

	// word-indexed program store
	word_t mem [imem_words];

	// load port, one word per clock
	always_ff @(posedge clk)
	begin
		if (prog_we)
			mem[prog_addr] <= prog_data;
	end

	// asynchronous read
	// past the end reads as halt so a runaway program stops
	always_comb
	begin
		if (addr < word_t'(imem_words))
			instr = mem[addr[aw-1:0]];
		else
			instr = {op_halt, {(xlen-6){1'b0}}};
	end

endmodule

// ==== verilog/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
	input  logic              clk,
	input  logic              rst,
	input  logic              run,
	output core_pkg::phase_e  phase,
	output core_pkg::word_t   fetch_pc,
	ex_res_if.consumer        res,
	output logic              halted
);
	import core_pkg::*;

	// program counter
	word_t pc;
	phase_e phase_next;

	assign fetch_pc = pc;

	////////////////////
	// phase sequencer
	////////////////////
	always_comb
	begin
		case (phase)
			// wait here while stopped or halted
			ph_fetch:   phase_next = (run && !halted) ? ph_decode : ph_fetch;
			ph_decode:  phase_next = ph_execute;
			ph_execute: phase_next = ph_result;
			default:    phase_next = ph_fetch;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			phase  <= ph_fetch;
			pc     <= '0;
			halted <= 1'b0;
		end
		else
		begin
			phase <= phase_next;
			// pc update at end of result phase
			if (phase == ph_result)
			begin
				if (res.is_halt)
				begin
					// pc stays on the halt, sticky until reset
					halted <= 1'b1;
				end
				else if (res.branch_taken)
				begin
					// beq redirect
					pc <= res.next_pc;
				end
				else
				begin
					pc <= pc + word_t'(1);
				end
			end
		end
	end

endmodule

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
	input  logic             clk,
	input  logic             rst,
	input  core_pkg::phase_e phase,
	input  core_pkg::word_t  instr,
	input  core_pkg::word_t  pc,
	rf_read_if.requester     rf,
	dec_ex_if.source         dx
);
	import core_pkg::*;
	import isa_pkg::*;

	////////////////////
	// field split
	////////////////////
	logic [5:0] opcode;
	logic [5:0] funct;
	logic [reg_addr_w-1:0] rs;
	logic [reg_addr_w-1:0] rt;
	logic [reg_addr_w-1:0] rd;
	word_t imm_sx;

	// decoded controls, before capture
	alu_op_e alu_op_d;
	logic [reg_addr_w-1:0] dest_d;
	logic use_imm;
	logic writes;
	logic load_d;
	logic store_d;
	logic branch_d;
	logic halt_d;

	assign opcode = instr[op_hi:op_lo];
	assign funct  = instr[fn_hi:fn_lo];
	assign rs     = instr[rs_hi:rs_lo];
	assign rt     = instr[rt_hi:rt_lo];
	assign rd     = instr[rd_hi:rd_lo];
	// sign extension, shared by addiu lw sw beq
	assign imm_sx = {{(xlen-16){instr[imm_hi]}}, instr[imm_hi:imm_lo]};

	// operand reads
	assign rf.rs_addr = rs;
	assign rf.rt_addr = rt;

	////////////////////
	// control decode
	////////////////////
	always_comb
	begin
		alu_op_d = alu_add;
		dest_d   = rt;
		use_imm  = 1'b0;
		writes   = 1'b0;
		load_d   = 1'b0;
		store_d  = 1'b0;
		branch_d = 1'b0;
		halt_d   = 1'b0;
		case (opcode)
			op_rtype:
			begin
				dest_d = rd;
				writes = 1'b1;
				case (funct)
					fn_addu: alu_op_d = alu_add;
					fn_subu: alu_op_d = alu_sub;
					fn_and:  alu_op_d = alu_and;
					fn_or:   alu_op_d = alu_or;
					fn_slt:  alu_op_d = alu_slt;
					// unknown function, no write
					default: writes = 1'b0;
				endcase
			end
			op_addiu:
			begin
				use_imm = 1'b1;
				writes  = 1'b1;
			end
			op_lw:
			begin
				use_imm = 1'b1;
				writes  = 1'b1;
				load_d  = 1'b1;
			end
			op_sw:
			begin
				use_imm = 1'b1;
				store_d = 1'b1;
			end
			op_beq:
			begin
				// compare on rs and rt
				alu_op_d = alu_sub;
				branch_d = 1'b1;
			end
			op_halt: halt_d = 1'b1;
			// anything else retires as a no-op
			default: ;
		endcase
	end

	// control capture at end of decode
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			dx.reg_we    <= 1'b0;
			dx.is_load   <= 1'b0;
			dx.is_store  <= 1'b0;
			dx.is_branch <= 1'b0;
			dx.is_halt   <= 1'b0;
		end
		else if (phase == ph_decode)
		begin
			// r0 writes dropped here
			dx.reg_we    <= writes && (dest_d != '0);
			dx.is_load   <= load_d;
			dx.is_store  <= store_d;
			dx.is_branch <= branch_d;
			dx.is_halt   <= halt_d;
		end
	end

	// operands and payload
	always_ff @(posedge clk)
	begin
		if (phase == ph_decode)
		begin
			dx.alu_op     <= alu_op_d;
			dx.opa        <= rf.rs_data;
			dx.opb        <= use_imm ? imm_sx : rf.rt_data;
			dx.store_data <= rf.rt_data;
			dx.dest       <= dest_d;
			dx.branch_off <= imm_sx;
			dx.pc         <= pc;
		end
	end

endmodule

// ==== verilog/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage #(
	parameter int dmem_words = 32
) (
	input  logic             clk,
	input  logic             rst,
	input  core_pkg::phase_e phase,
	dec_ex_if.sink           dx,
	ex_res_if.source         xr
);
	import core_pkg::*;
	import isa_pkg::*;

	localparam int daw = $clog2(dmem_words);

	// data memory, word indexed
	word_t dmem [dmem_words];

	word_t alu_y;
	word_t load_data;
	word_t branch_target;
	word_t seq_pc;
	logic equal;
	logic taken;

	////////////////////
	// alu
	////////////////////
	always_comb
	begin
		case (dx.alu_op)
			alu_add: alu_y = dx.opa + dx.opb;
			alu_sub: alu_y = dx.opa - dx.opb;
			alu_and: alu_y = dx.opa & dx.opb;
			alu_or:  alu_y = dx.opa | dx.opb;
			// signed compare
			alu_slt: alu_y = ($signed(dx.opa) < $signed(dx.opb)) ? word_t'(1) : '0;
			default: alu_y = '0;
		endcase
	end

	// beq compare, opb holds rt for beq
	assign equal = (dx.opa == dx.opb);
	assign taken = dx.is_branch && equal;

	// target is pc+1 plus offset
	assign seq_pc        = dx.pc + word_t'(1);
	assign branch_target = seq_pc + dx.branch_off;

	// lw and sw address from the alu sum, low bits index
	assign load_data = dmem[alu_y[daw-1:0]];

	// store at end of execute
	always_ff @(posedge clk)
	begin
		if (phase == ph_execute && dx.is_store)
			dmem[alu_y[daw-1:0]] <= dx.store_data;
	end

	////////////////////
	// result register
	////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			xr.reg_we       <= 1'b0;
			xr.mem_we       <= 1'b0;
			xr.branch_taken <= 1'b0;
			xr.is_halt      <= 1'b0;
		end
		else if (phase == ph_execute)
		begin
			xr.reg_we       <= dx.reg_we;
			xr.mem_we       <= dx.is_store;
			xr.branch_taken <= taken;
			xr.is_halt      <= dx.is_halt;
		end
	end

	always_ff @(posedge clk)
	begin
		if (phase == ph_execute)
		begin
			// store data reported as the commit value
			if (dx.is_store)
				xr.result <= dx.store_data;
			else if (dx.is_load)
				xr.result <= load_data;
			else
				xr.result <= alu_y;
			xr.dest     <= dx.dest;
			xr.mem_addr <= alu_y;
			xr.pc       <= dx.pc;
			xr.next_pc  <= taken ? branch_target : seq_pc;
		end
	end

endmodule

// ==== verilog/result_stage.sv ====
`timescale 1ns/1ps

module result_stage (
	input  logic                            clk,
	input  logic                            rst,
	input  core_pkg::phase_e                phase,
	ex_res_if.sink                          xr,
	rf_read_if.provider                     rf,
	output logic                            commit,
	output core_pkg::word_t                 commit_pc,
	output logic                            commit_we,
	output logic [core_pkg::reg_addr_w-1:0] commit_reg,
	output core_pkg::word_t                 commit_data,
	output logic                            commit_mem_we,
	output core_pkg::word_t                 commit_mem_addr
);
	import core_pkg::*;

	localparam int nregs = 2**reg_addr_w;

	// register file, entry 0 never written
	word_t regs [nregs];
	logic in_result;
	logic wb;

	assign in_result = (phase == ph_result);
	assign wb        = in_result && xr.reg_we && (xr.dest != '0);

	// write-back at end of result phase
	always_ff @(posedge clk)
	begin
		if (wb)
			regs[xr.dest] <= xr.result;
	end

	// r0 held at zero on read
	assign rf.rs_data = (rf.rs_addr == '0) ? '0 : regs[rf.rs_addr];
	assign rf.rt_data = (rf.rt_addr == '0) ? '0 : regs[rf.rt_addr];

	////////////////////
	// commit report
	////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			commit        <= 1'b0;
			commit_we     <= 1'b0;
			commit_mem_we <= 1'b0;
		end
		else
		begin
			// one pulse per retired instruction, halt does not retire
			commit        <= in_result && !xr.is_halt;
			commit_we     <= wb;
			commit_mem_we <= in_result && xr.mem_we;
		end
	end

	always_ff @(posedge clk)
	begin
		if (in_result)
		begin
			commit_pc       <= xr.pc;
			commit_reg      <= xr.dest;
			commit_data     <= xr.result;
			commit_mem_addr <= xr.mem_addr;
		end
	end

endmodule

// ==== verilog/mips_core.sv ====
`timescale 1ns/1ps

module mips_core #(
	parameter int imem_words = 32,
	parameter int dmem_words = 32
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            run,
	// program load, only while run is low
	input  logic                            prog_we,
	input  logic [$clog2(imem_words)-1:0]   prog_addr,
	input  core_pkg::word_t                 prog_data,
	// commit report
	output logic                            commit,
	output core_pkg::word_t                 commit_pc,
	output logic                            commit_we,
	output logic [core_pkg::reg_addr_w-1:0] commit_reg,
	output core_pkg::word_t                 commit_data,
	output logic                            commit_mem_we,
	output core_pkg::word_t                 commit_mem_addr,
	output logic                            halted
);
	import core_pkg::*;

	phase_e phase;
	word_t fetch_pc;
	word_t instr;

	// stage links
	rf_read_if rf_bus ();
	dec_ex_if  dx_bus ();
	ex_res_if  xr_bus ();

	////////////////////
	// program store and fetch
	////////////////////
	instr_mem #(
		.imem_words (imem_words)
	) u_imem (
		.clk       (clk),
		.prog_we   (prog_we),
		.prog_addr (prog_addr),
		.prog_data (prog_data),
		.addr      (fetch_pc),
		.instr     (instr)
	);

	fetch_unit u_fetch (
		.clk      (clk),
		.rst      (rst),
		.run      (run),
		.phase    (phase),
		.fetch_pc (fetch_pc),
		.res      (xr_bus.consumer),
		.halted   (halted)
	);

	////////////////////
	// decode, execute, result
	////////////////////
	decode_stage u_decode (
		.clk   (clk),
		.rst   (rst),
		.phase (phase),
		.instr (instr),
		.pc    (fetch_pc),
		.rf    (rf_bus.requester),
		.dx    (dx_bus.source)
	);

	execute_stage #(
		.dmem_words (dmem_words)
	) u_execute (
		.clk   (clk),
		.rst   (rst),
		.phase (phase),
		.dx    (dx_bus.sink),
		.xr    (xr_bus.source)
	);

	result_stage u_result (
		.clk             (clk),
		.rst             (rst),
		.phase           (phase),
		.xr              (xr_bus.sink),
		.rf              (rf_bus.provider),
		.commit          (commit),
		.commit_pc       (commit_pc),
		.commit_we       (commit_we),
		.commit_reg      (commit_reg),
		.commit_data     (commit_data),
		.commit_mem_we   (commit_mem_we),
		.commit_mem_addr (commit_mem_addr)
	);

endmodule

// ==== verif/mips_core_checker.sv ====
`timescale 1ns/1ps

module mips_core_checker (
	input logic                            clk,
	input logic                            rst,
	input logic                            run,
	input logic                            prog_we,
	input logic                            commit,
	input logic                            commit_we,
	input logic [core_pkg::reg_addr_w-1:0] commit_reg,
	input logic                            halted
);

	// failed assertions, summed into the testbench summary
	int fail_count = 0;

	////////////////////
	// commit port
	////////////////////
	// one instruction every four cycles
	commit_single: assert property (@(posedge clk) disable iff (rst) commit |=> !commit)
	else
	begin
		fail_count++;
		$error("commit high in two consecutive cycles");
	end

	// r0 writes are dropped
	commit_r0: assert property (@(posedge clk) disable iff (rst) commit_we |-> commit_reg != '0)
	else
	begin
		fail_count++;
		$error("commit_we high with commit_reg zero");
	end

	commit_halt: assert property (@(posedge clk) disable iff (rst) !(commit && halted))
	else
	begin
		fail_count++;
		$error("commit while halted");
	end

	////////////////////
	// control inputs
	////////////////////
	// program load only while stopped
	load_stopped: assert property (@(posedge clk) disable iff (rst) !(prog_we && run))
	else
	begin
		fail_count++;
		$error("prog_we high while run is high");
	end

endmodule

bind mips_core mips_core_checker chk (
	.clk        (clk),
	.rst        (rst),
	.run        (run),
	.prog_we    (prog_we),
	.commit     (commit),
	.commit_we  (commit_we),
	.commit_reg (commit_reg),
	.halted     (halted)
);

// ==== verif/mips_core_tb.sv ====
`timescale 1ns/1ps

module mips_core_tb;

	// program store deep enough for the random program
	localparam int imem_words = 64;
	localparam int dmem_words = 32;
	localparam int iaw = $clog2(imem_words);
	localparam int daw = $clog2(dmem_words);

	// dynamic instruction counts, halt included
	// alu 9, memory 14, branch 17, r0 and overrun 6, random 41
	localparam int n_programs = 5;
	localparam int n_instrs = 9 + 14 + 17 + 6 + 41;
	localparam int cycle_limit = 4 * n_instrs + 100 * n_programs;

	////////////////////
	// encodings
	////////////////////
	localparam logic [5:0] op_rtype = 6'b000000;
	localparam logic [5:0] op_addiu = 6'b001001;
	localparam logic [5:0] op_beq   = 6'b000100;
	localparam logic [5:0] op_lw    = 6'b100011;
	localparam logic [5:0] op_sw    = 6'b101011;
	localparam logic [5:0] op_halt  = 6'b111111;
	localparam logic [5:0] fn_addu  = 6'b100001;
	localparam logic [5:0] fn_subu  = 6'b100011;
	localparam logic [5:0] fn_and   = 6'b100100;
	localparam logic [5:0] fn_or    = 6'b100101;
	localparam logic [5:0] fn_slt   = 6'b101010;
	localparam logic [31:0] halt_word = {op_halt, 26'd0};
	// galois feedback, x^32 + x^22 + x^2 + x + 1
	localparam logic [31:0] taps = 32'h8020_0003;

	// expected commit fields
	typedef struct packed {
		logic        halt;
		logic [31:0] pc;
		logic        we;
		logic [4:0]  dest;
		logic [31:0] data;
		logic        mem_we;
		logic [31:0] mem_addr;
	} commit_t;

	logic clk;
	logic rst;
	logic run;
	logic prog_we;
	logic [iaw-1:0] prog_addr;
	logic [31:0] prog_data;
	logic commit;
	logic [31:0] commit_pc;
	logic commit_we;
	logic [4:0] commit_reg;
	logic [31:0] commit_data;
	logic commit_mem_we;
	logic [31:0] commit_mem_addr;
	logic halted;

	// reference machine state
	logic [31:0] ref_pc;
	logic [31:0] ref_regs [32];
	logic [31:0] ref_imem [imem_words];
	logic [31:0] ref_dmem [dmem_words];

	logic [31:0] prog_q [$];
	logic [31:0] lfsr;
	commit_t exp_c;
	int cycles = 0;
	int last_commit = -1;
	int value_errs = 0;
	int other_errs = 0;
	int n_commits = 0;

	mips_core #(
		.imem_words (imem_words),
		.dmem_words (dmem_words)
	) DUT (
		.clk             (clk),
		.rst             (rst),
		.run             (run),
		.prog_we         (prog_we),
		.prog_addr       (prog_addr),
		.prog_data       (prog_data),
		.commit          (commit),
		.commit_pc       (commit_pc),
		.commit_we       (commit_we),
		.commit_reg      (commit_reg),
		.commit_data     (commit_data),
		.commit_mem_we   (commit_mem_we),
		.commit_mem_addr (commit_mem_addr),
		.halted          (halted)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	////////////////////
	// helpers
	////////////////////
	function automatic logic [31:0] r_op(logic [5:0] fn, logic [4:0] rd, logic [4:0] rs,
		logic [4:0] rt);
		return {op_rtype, rs, rt, rd, 5'd0, fn};
	endfunction

	// field order as in the word: rs then rt
	function automatic logic [31:0] i_op(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// one lfsr step per bit, first bit ends up msb
	function automatic logic [31:0] take_bits(int n);
		logic [31:0] v;
		logic b;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			b = lfsr[0];
			lfsr = (lfsr >> 1) ^ (b ? taps : 32'd0);
			v = {v[30:0], b};
		end
		return v;
	endfunction

	function automatic logic [5:0] alu_fn(logic [2:0] k);
		case (k)
			3'd0: return fn_addu;
			3'd1: return fn_subu;
			3'd2: return fn_and;
			3'd3: return fn_or;
			default: return fn_slt;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (act !== exp)
		begin
			value_errs++;
			$display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	////////////////////
	// reference model
	////////////////////
	// one instruction on the testbench copy of the machine
	function automatic commit_t ref_step();
		commit_t c;
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] ea;
		logic [31:0] nxt;
		logic [31:0] val;
		logic [4:0] dst;
		logic wr;
		c = '0;
		c.pc = ref_pc;
		// past the store end reads as halt
		if (ref_pc < 32'(imem_words))
			ins = ref_imem[ref_pc[iaw-1:0]];
		else
			ins = halt_word;
		a = ref_regs[ins[25:21]];
		b = ref_regs[ins[20:16]];
		imm = {{16{ins[15]}}, ins[15:0]};
		ea = a + imm;
		nxt = ref_pc + 32'd1;
		dst = ins[20:16];
		val = '0;
		wr = 1'b0;
		case (ins[31:26])
			op_rtype:
			begin
				dst = ins[15:11];
				wr = 1'b1;
				case (ins[5:0])
					fn_addu: val = a + b;
					fn_subu: val = a - b;
					fn_and:  val = a & b;
					fn_or:   val = a | b;
					fn_slt:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: wr = 1'b0;
				endcase
			end
			op_addiu:
			begin
				wr = 1'b1;
				val = ea;
			end
			op_lw:
			begin
				wr = 1'b1;
				val = ref_dmem[ea[daw-1:0]];
			end
			op_sw:
			begin
				c.mem_we = 1'b1;
				c.mem_addr = ea;
				c.data = b;
				ref_dmem[ea[daw-1:0]] = b;
			end
			// target is pc+1 plus offset
			op_beq:
			begin
				if (a == b)
					nxt = nxt + imm;
			end
			op_halt:
			begin
				c.halt = 1'b1;
				nxt = ref_pc;
			end
			default: ;
		endcase
		// r0 writes vanish
		if (wr && dst != 5'd0)
		begin
			ref_regs[dst] = val;
			c.we = 1'b1;
			c.dest = dst;
			c.data = val;
		end
		ref_pc = nxt;
		return c;
	endfunction

	////////////////////
	// compare process
	////////////////////
	always @(negedge clk)
	begin
		if (commit === 1'b1)
		begin
			n_commits++;
			if (halted)
			begin
				other_errs++;
				$display("commit seen while halted at %0t", $time);
			end
			if (!run)
			begin
				other_errs++;
				$display("commit seen while run was low at %0t", $time);
			end
			// fixed four cycle retirement
			if (last_commit >= 0 && cycles - last_commit != 4)
			begin
				other_errs++;
				$display("commit at %0t came %0d cycles after the one before, not 4",
					$time, cycles - last_commit);
			end
			last_commit = cycles;
			exp_c = ref_step();
			if (exp_c.halt)
			begin
				other_errs++;
				$display("commit reported for a halt instruction at %0t", $time);
			end
			else
			begin
				check_value("commit_pc", exp_c.pc, commit_pc);
				check_value("commit_we", 32'(exp_c.we), 32'(commit_we));
				if (exp_c.we)
				begin
					check_value("commit_reg", 32'(exp_c.dest), 32'(commit_reg));
					check_value("commit_data", exp_c.data, commit_data);
				end
				check_value("commit_mem_we", 32'(exp_c.mem_we), 32'(commit_mem_we));
				if (exp_c.mem_we)
				begin
					check_value("commit_mem_addr", exp_c.mem_addr, commit_mem_addr);
					check_value("commit_data", exp_c.data, commit_data);
				end
			end
		end
	end

	task automatic finish_run();
		int total;
		total = value_errs + other_errs + DUT.chk.fail_count;
		$display("errors: %0d mismatches, %0d other, %0d assertions; %0d commits checked",
			value_errs, other_errs, DUT.chk.fail_count, n_commits);
		if (total == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	endtask

	// cycle count and watchdog
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit)
		begin
			other_errs++;
			$display("timeout before halt after %0d cycles", cycles);
			finish_run();
		end
	end

	////////////////////
	// program flow
	////////////////////
	task automatic reset_core();
		@(posedge clk);
		#1;
		rst = 1'b1;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		@(negedge clk);
		check_value("commit", 32'd0, 32'(commit));
		check_value("commit_we", 32'd0, 32'(commit_we));
		check_value("commit_mem_we", 32'd0, 32'(commit_mem_we));
		check_value("halted", 32'd0, 32'(halted));
	endtask

	// one word per clock, mirrored into the reference
	task automatic load_program();
		for (int i = 0; i < prog_q.size(); i++)
		begin
			@(posedge clk);
			#1;
			prog_we = 1'b1;
			prog_addr = iaw'(i);
			prog_data = prog_q[i];
			ref_imem[i] = prog_q[i];
		end
		@(posedge clk);
		#1;
		prog_we = 1'b0;
	endtask

	task automatic run_program();
		commit_t c;
		reset_core();
		load_program();
		// idle with run low, nothing may retire
		repeat (4) @(posedge clk);
		ref_pc = '0;
		last_commit = -1;
		#1;
		run = 1'b1;
		while (halted !== 1'b1)
			@(negedge clk);
		c = ref_step();
		if (!c.halt)
		begin
			other_errs++;
			$display("core halted before the reference reached a halt, ref pc %0d", c.pc);
		end
		// stay halted, watch for stray commits
		repeat (8) @(negedge clk);
		check_value("halted", 32'd1, 32'(halted));
		@(posedge clk);
		#1;
		run = 1'b0;
	endtask

	////////////////////
	// programs
	////////////////////
	task automatic build_alu_prog();
		prog_q.delete();
		prog_q.push_back(i_op(op_addiu, 5'd0, 5'd1, 16'd7));
		prog_q.push_back(i_op(op_addiu, 5'd0, 5'd2, 16'hfffd));
		prog_q.push_back(r_op(fn_addu, 5'd3, 5'd1, 5'd2));
		prog_q.push_back(r_op(fn_subu, 5'd4, 5'd1, 5'd2));
		prog_q.push_back(r_op(fn_and, 5'd5, 5'd1, 5'd2));
		prog_q.push_back(r_op(fn_or, 5'd6, 5'd1, 5'd2));
		// signed, -3 < 7
		prog_q.push_back(r_op(fn_slt, 5'd7, 5'd2, 5'd1));
		prog_q.push_back(r_op(fn_slt, 5'd8, 5'd1, 5'd2));
		prog_q.push_back(halt_word);
	endtask

	// stores, loads and an add, as in the sample program
	task automatic build_mem_prog();
		prog_q.delete();
		prog_q.push_back(i_op(op_addiu, 5'd0, 5'd1, 16'd100));
		prog_q.push_back(i_op(op_addiu, 5'd0, 5'd2, 16'd23));
		prog_q.push_back(i_op(op_sw, 5'd0, 5'd1, 16'd4));
		prog_q.push_back(i_op(op_sw, 5'd0, 5'd2, 16'd5));
		prog_q.push_back(i_op(op_addiu, 5'd0, 5'd9, 16'd3));
		prog_q.push_back(i_op(op_sw, 5'd9, 5'd2, 16'd3));
		prog_q.push_back(i_op(op_lw, 5'd0, 5'd3, 16'd4));
		prog_q.push_back(i_op(op_lw, 5'd9, 5'd4, 16'd2));
		prog_q.push_back(r_op(fn_addu, 5'd5, 5'd3, 5'd4));
		prog_q.push_back(i_op(op_lw, 5'd9, 5'd6, 16'd3));
		prog_q.push_back(i_op(op_addiu, 5'd0, 5'd10, 16'd8));
		// negative offset, word 4
		prog_q.push_back(i_op(op_lw, 5'd10, 5'd8, 16'hfffc));
		prog_q.push_back(r_op(fn_addu, 5'd7, 5'd6, 5'd8));
		prog_q.push_back(halt_word);
	endtask

	task automatic build_branch_prog();
		prog_q.delete();
		prog_q.push_back(i_op(op_addiu, 5'd0, 5'd1, 16'd3));
		prog_q.push_back(i_op(op_addiu, 5'd0, 5'd2, 16'd0));
		prog_q.push_back(i_op(op_addiu, 5'd0, 5'd3, 16'd1));
		// loop body at 3, three passes
		prog_q.push_back(i_op(op_addiu, 5'd2, 5'd2, 16'd5));
		prog_q.push_back(i_op(op_addiu, 5'd1, 5'd1, 16'hffff));
		prog_q.push_back(i_op(op_beq, 5'd1, 5'd0, 16'd1));
		// backward, 7 - 4
		prog_q.push_back(i_op(op_beq, 5'd0, 5'd0, 16'hfffc));
		prog_q.push_back(i_op(op_beq, 5'd1, 5'd2, 16'd1));
		prog_q.push_back(i_op(op_addiu, 5'd3, 5'd3, 16'd9));
		prog_q.push_back(halt_word);
	endtask

	// r0 writes, then a branch past the store end
	task automatic build_r0_prog();
		prog_q.delete();
		prog_q.push_back(i_op(op_addiu, 5'd0, 5'd1, 16'd2));
		prog_q.push_back(i_op(op_addiu, 5'd1, 5'd0, 16'd5));
		prog_q.push_back(r_op(fn_addu, 5'd0, 5'd1, 5'd1));
		prog_q.push_back(r_op(fn_addu, 5'd4, 5'd0, 5'd0));
		prog_q.push_back(i_op(op_beq, 5'd0, 5'd0, 16'd100));
	endtask

	task automatic build_random_prog();
		logic [2:0] k;
		logic [4:0] rd;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] ma;
		logic [31:0] stored;
		prog_q.delete();
		stored = '0;
		// r1 to r7 seeded first
		for (int r = 1; r < 8; r++)
			prog_q.push_back(i_op(op_addiu, 5'd0, 5'(r), 16'(take_bits(16))));
		while (prog_q.size() < 40)
		begin
			k = 3'(take_bits(3));
			rd = 5'(take_bits(3));
			rs = 5'(take_bits(3));
			rt = 5'(take_bits(3));
			ma = 5'(take_bits(5));
			case (k)
				3'd5: prog_q.push_back(i_op(op_addiu, rs, rd, 16'(take_bits(16))));
				3'd6:
				begin
					// load only from a word written here
					if (stored[ma])
						prog_q.push_back(i_op(op_lw, 5'd0, rd, {11'd0, ma}));
					else
					begin
						prog_q.push_back(i_op(op_sw, 5'd0, rt, {11'd0, ma}));
						stored[ma] = 1'b1;
					end
				end
				3'd7:
				begin
					prog_q.push_back(i_op(op_sw, 5'd0, rt, {11'd0, ma}));
					stored[ma] = 1'b1;
				end
				default: prog_q.push_back(r_op(alu_fn(k), rd, rs, rt));
			endcase
		end
		prog_q.push_back(halt_word);
	endtask

	////////////////////
	// main sequence
	////////////////////
	initial
	begin
		rst = 1'b1;
		run = 1'b0;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		lfsr = 32'h85a2_09bf;
		ref_pc = '0;
		for (int i = 0; i < 32; i++)
			ref_regs[i] = '0;
		for (int i = 0; i < imem_words; i++)
			ref_imem[i] = halt_word;
		for (int i = 0; i < dmem_words; i++)
			ref_dmem[i] = '0;

		build_alu_prog();
		run_program();
		build_mem_prog();
		run_program();
		build_branch_prog();
		run_program();
		build_r0_prog();
		run_program();
		build_random_prog();
		run_program();

		finish_run();
	end

endmodule

// ==== build.f ====
verilog/isa_pkg.sv
verilog/core_pkg.sv
verilog/core_if.sv
verilog/instr_mem.sv
verilog/fetch_unit.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/result_stage.sv
verilog/mips_core.sv
verif/mips_core_checker.sv
verif/mips_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the testbench with Verilator, verdict from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module mips_core_tb -f build.f -o vsim \
	> build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/vsim +verilator+error+limit+100 > sim.log 2>&1 || echo "simulator returned an error"
cat sim.log
grep -qx "TEST PASSED" sim.log && exit 0 || exit 1
